//--- verilog/core_pkg.sv
`default_nettype none

package core_pkg;

    // word and register index widths
    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;

    // major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111
    } opcode_e;

    // operations the execute ALU can perform
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS_B
    } alu_op_e;

    // addi x0, x0, 0
    localparam word_t NOP_INST = 32'h0000_0013;

endpackage

`default_nettype wire

//--- verilog/bus_pkg.sv
`default_nettype none

package bus_pkg;

    // top address nibble picks the slave
    localparam int SEL_MSB = 31;
    localparam int SEL_LSB = 28;

    typedef enum logic [SEL_MSB-SEL_LSB:0] {
        SLV_ROM = 4'h0,
        SLV_RAM = 4'h1
    } slave_e;

    // who owns the bus this cycle
    typedef enum logic {
        MST_EX,
        MST_FETCH
    } master_e;

endpackage

`default_nettype wire

//--- verilog/fetch_stage.sv
`default_nettype none

module fetch_stage #(
    parameter core_pkg::word_t RESET_PC = 32'h0000_0000
) (
    input  wire                  clk,
    input  wire                  rst_n_i,
    input  wire                  hold_i,
    input  wire                  halt_i,
    input  wire                  jump_i,
    input  wire core_pkg::word_t jump_addr_i,
    input  wire core_pkg::word_t fetch_data_i,
    output core_pkg::word_t      pc_o,
    output core_pkg::word_t      inst_o,
    output core_pkg::word_t      inst_addr_o
);

    logic stall;

    assign stall = hold_i || halt_i;

    // pc register, a jump beats a stall so a branch under halt is not lost
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pc_o <= RESET_PC;
        end else if (jump_i) begin
            pc_o <= jump_addr_i;
        end else if (!stall) begin
            pc_o <= pc_o + 32'd4;
        end
    end

    // fetch/decode latch
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            inst_o <= core_pkg::NOP_INST;
        end else if (jump_i || stall) begin
            // fetched word is stale or was never fetched
            inst_o <= core_pkg::NOP_INST;
        end else begin
            inst_o <= fetch_data_i;
        end
    end

    // address travels with the word, only meaningful for real instructions
    always_ff @(posedge clk) begin
        inst_addr_o <= pc_o;
    end

endmodule

`default_nettype wire

//--- verilog/regs.sv
`default_nettype none

module regs (
    input  wire                      clk,
    input  wire                      rst_n_i,
    input  wire core_pkg::reg_addr_t rs1_addr_i,
    input  wire core_pkg::reg_addr_t rs2_addr_i,
    input  wire core_pkg::reg_addr_t rd_addr_i,
    input  wire core_pkg::reg_addr_t jtag_addr_i,
    input  wire                      rd_we_i,
    input  wire                      jtag_we_i,
    input  wire core_pkg::word_t     rd_data_i,
    input  wire core_pkg::word_t     jtag_data_i,
    output core_pkg::word_t          rs1_data_o,
    output core_pkg::word_t          rs2_data_o,
    output core_pkg::word_t          jtag_data_o
);

    localparam int NUM_REGS = 32;

    core_pkg::word_t rf [NUM_REGS];

    // core write is issued last so it wins a same-register collision
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                rf[i] <= '0;
            end
        end else begin
            if (jtag_we_i && jtag_addr_i != '0) begin
                rf[jtag_addr_i] <= jtag_data_i;
            end
            if (rd_we_i && rd_addr_i != '0) begin
                rf[rd_addr_i] <= rd_data_i;
            end
        end
    end

    // execute reads and writes in the same cycle, so the core ports
    // read the array; forwarding rd_data here would loop through the ALU
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : rf[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : rf[rs2_addr_i];

    // debug read sees a write landing this cycle
    always_comb begin
        if (jtag_addr_i == '0) begin
            jtag_data_o = '0;
        end else if (rd_we_i && rd_addr_i == jtag_addr_i) begin
            jtag_data_o = rd_data_i;
        end else begin
            jtag_data_o = rf[jtag_addr_i];
        end
    end

endmodule

`default_nettype wire

//--- verilog/decode_execute.sv
`default_nettype none

module decode_execute (
    input  wire core_pkg::word_t  inst_i,
    input  wire core_pkg::word_t  inst_addr_i,
    input  wire core_pkg::word_t  rs1_data_i,
    input  wire core_pkg::word_t  rs2_data_i,
    input  wire core_pkg::word_t  mem_rdata_i,
    output core_pkg::reg_addr_t   rs1_addr_o,
    output core_pkg::reg_addr_t   rs2_addr_o,
    output core_pkg::reg_addr_t   rd_addr_o,
    output logic                  rd_we_o,
    output core_pkg::word_t       rd_data_o,
    output logic                  mem_req_o,
    output logic                  mem_we_o,
    output core_pkg::word_t       mem_addr_o,
    output core_pkg::word_t       mem_wdata_o,
    output logic                  jump_o,
    output core_pkg::word_t       jump_addr_o
);

    // funct3 codes used by the subset
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;
    localparam logic [2:0] F3_WORD = 3'b010;
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    logic [2:0]        funct3;
    logic [6:0]        funct7;
    core_pkg::opcode_e opcode;
    logic              op_valid;
    core_pkg::alu_op_e alu_op;
    logic              alu_ok;
    core_pkg::word_t   imm_i;
    core_pkg::word_t   imm_s;
    core_pkg::word_t   imm_b;
    core_pkg::word_t   imm_u;
    core_pkg::word_t   imm_j;
    core_pkg::word_t   alu_b;
    core_pkg::word_t   alu_res;
    core_pkg::word_t   agu_addr;
    core_pkg::word_t   link_addr;

    assign funct3     = inst_i[14:12];
    assign funct7     = inst_i[31:25];
    assign rd_addr_o  = inst_i[11:7];
    assign rs1_addr_o = inst_i[19:15];
    assign rs2_addr_o = inst_i[24:20];

    assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_s = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_b = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    assign imm_u = {inst_i[31:12], 12'b0};
    assign imm_j = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

    // major opcode classification
    always_comb begin
        op_valid = 1'b1;
        opcode   = core_pkg::OP_IMM;
        case (inst_i[6:0])
            core_pkg::OP_LUI:    opcode = core_pkg::OP_LUI;
            core_pkg::OP_IMM:    opcode = core_pkg::OP_IMM;
            core_pkg::OP_REG:    opcode = core_pkg::OP_REG;
            core_pkg::OP_LOAD:   opcode = core_pkg::OP_LOAD;
            core_pkg::OP_STORE:  opcode = core_pkg::OP_STORE;
            core_pkg::OP_BRANCH: opcode = core_pkg::OP_BRANCH;
            core_pkg::OP_JAL:    opcode = core_pkg::OP_JAL;
            default:             op_valid = 1'b0;
        endcase
    end

    // alu operation from the function fields
    always_comb begin
        alu_op = core_pkg::ALU_ADD;
        alu_ok = 1'b0;
        if (op_valid && opcode == core_pkg::OP_LUI) begin
            alu_op = core_pkg::ALU_PASS_B;
            alu_ok = 1'b1;
        end else if (op_valid && opcode == core_pkg::OP_IMM) begin
            alu_ok = (funct3 == F3_ADD);
        end else if (op_valid && opcode == core_pkg::OP_REG) begin
            alu_ok = 1'b1;
            case ({funct7, funct3})
                {F7_BASE, F3_ADD}: alu_op = core_pkg::ALU_ADD;
                {F7_ALT, F3_ADD}:  alu_op = core_pkg::ALU_SUB;
                {F7_BASE, F3_AND}: alu_op = core_pkg::ALU_AND;
                {F7_BASE, F3_OR}:  alu_op = core_pkg::ALU_OR;
                {F7_BASE, F3_XOR}: alu_op = core_pkg::ALU_XOR;
                default:           alu_ok = 1'b0;
            endcase
        end
    end

    assign alu_b = (opcode == core_pkg::OP_REG) ? rs2_data_i :
                   (opcode == core_pkg::OP_LUI) ? imm_u : imm_i;

    always_comb begin
        case (alu_op)
            core_pkg::ALU_ADD:    alu_res = rs1_data_i + alu_b;
            core_pkg::ALU_SUB:    alu_res = rs1_data_i - alu_b;
            core_pkg::ALU_AND:    alu_res = rs1_data_i & alu_b;
            core_pkg::ALU_OR:     alu_res = rs1_data_i | alu_b;
            core_pkg::ALU_XOR:    alu_res = rs1_data_i ^ alu_b;
            core_pkg::ALU_PASS_B: alu_res = alu_b;
            default:              alu_res = '0;
        endcase
    end

    // load/store address, and the link value for jal
    assign agu_addr  = rs1_data_i + ((opcode == core_pkg::OP_STORE) ? imm_s : imm_i);
    assign link_addr = inst_addr_i + 32'd4;

    assign mem_addr_o  = agu_addr;
    assign mem_wdata_o = rs2_data_i;
    assign jump_addr_o = inst_addr_i + ((opcode == core_pkg::OP_JAL) ? imm_j : imm_b);

    // write-back, memory requests and control flow
    always_comb begin
        rd_we_o   = alu_ok;
        rd_data_o = alu_res;
        mem_req_o = 1'b0;
        mem_we_o  = 1'b0;
        jump_o    = 1'b0;
        if (op_valid) begin
            case (opcode)
                core_pkg::OP_LOAD: begin
                    if (funct3 == F3_WORD) begin
                        mem_req_o = 1'b1;
                        rd_we_o   = 1'b1;
                        rd_data_o = mem_rdata_i;
                    end
                end
                core_pkg::OP_STORE: begin
                    if (funct3 == F3_WORD) begin
                        mem_req_o = 1'b1;
                        mem_we_o  = 1'b1;
                    end
                end
                core_pkg::OP_BRANCH: begin
                    if (funct3 == F3_BEQ) begin
                        jump_o = (rs1_data_i == rs2_data_i);
                    end else if (funct3 == F3_BNE) begin
                        jump_o = (rs1_data_i != rs2_data_i);
                    end
                end
                core_pkg::OP_JAL: begin
                    jump_o    = 1'b1;
                    rd_we_o   = 1'b1;
                    rd_data_o = link_addr;
                end
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/rib_bus.sv
`default_nettype none

module rib_bus (
    input  wire                  ex_req_i,
    input  wire                  ex_we_i,
    input  wire core_pkg::word_t ex_addr_i,
    input  wire core_pkg::word_t ex_wdata_i,
    input  wire core_pkg::word_t fetch_addr_i,
    input  wire core_pkg::word_t s0_data_i,
    input  wire core_pkg::word_t s1_data_i,
    output core_pkg::word_t      ex_rdata_o,
    output core_pkg::word_t      fetch_data_o,
    output logic                 hold_o,
    output core_pkg::word_t      s0_addr_o,
    output core_pkg::word_t      s0_data_o,
    output core_pkg::word_t      s1_addr_o,
    output core_pkg::word_t      s1_data_o,
    output logic                 s0_we_o,
    output logic                 s1_we_o
);

    bus_pkg::master_e grant;
    bus_pkg::slave_e  slave;
    logic             slave_hit;
    core_pkg::word_t  grant_addr;
    core_pkg::word_t  rdata;
    logic             wr_en;

    // execute master has priority over fetch
    assign grant      = ex_req_i ? bus_pkg::MST_EX : bus_pkg::MST_FETCH;
    assign hold_o     = (grant == bus_pkg::MST_EX);
    assign grant_addr = (grant == bus_pkg::MST_EX) ? ex_addr_i : fetch_addr_i;
    assign wr_en      = (grant == bus_pkg::MST_EX) && ex_we_i;

    // slave decode on the top nibble
    always_comb begin
        slave     = bus_pkg::SLV_ROM;
        slave_hit = 1'b1;
        case (grant_addr[bus_pkg::SEL_MSB:bus_pkg::SEL_LSB])
            bus_pkg::SLV_ROM: slave = bus_pkg::SLV_ROM;
            bus_pkg::SLV_RAM: slave = bus_pkg::SLV_RAM;
            default:          slave_hit = 1'b0;
        endcase
    end

    assign s0_addr_o = grant_addr;
    assign s1_addr_o = grant_addr;
    assign s0_data_o = ex_wdata_i;
    assign s1_data_o = ex_wdata_i;

    assign s0_we_o = wr_en && slave_hit && (slave == bus_pkg::SLV_ROM);
    assign s1_we_o = wr_en && slave_hit && (slave == bus_pkg::SLV_RAM);

    // unmapped regions read as zero
    always_comb begin
        if (!slave_hit) begin
            rdata = '0;
        end else if (slave == bus_pkg::SLV_RAM) begin
            rdata = s1_data_i;
        end else begin
            rdata = s0_data_i;
        end
    end

    assign ex_rdata_o   = (grant == bus_pkg::MST_EX) ? rdata : '0;
    assign fetch_data_o = (grant == bus_pkg::MST_FETCH) ? rdata : '0;

endmodule

`default_nettype wire

//--- verilog/core.sv
`default_nettype none

module core #(
    parameter core_pkg::word_t RESET_PC = 32'h0000_0000
) (
    input  wire                      clk,
    input  wire                      rst_n_i,

    // debug register access
    input  wire core_pkg::reg_addr_t jtag_reg_addr_i,
    input  wire core_pkg::word_t     jtag_reg_data_i,
    input  wire                      jtag_reg_we_i,
    output core_pkg::word_t          jtag_reg_data_o,
    input  wire                      jtag_halt_flag_i,

    // slave 0, instruction rom
    output core_pkg::word_t          s0_addr_o,
    output core_pkg::word_t          s0_data_o,
    input  wire core_pkg::word_t     s0_data_i,
    output logic                     s0_we_o,

    // slave 1, data ram
    output core_pkg::word_t          s1_addr_o,
    output core_pkg::word_t          s1_data_o,
    input  wire core_pkg::word_t     s1_data_i,
    output logic                     s1_we_o
);

    // fetch side
    wire core_pkg::word_t     pc;
    wire core_pkg::word_t     fetch_data;
    wire                      hold;
    wire core_pkg::word_t     inst;
    wire core_pkg::word_t     inst_addr;

    // execute side
    wire                      jump;
    wire core_pkg::word_t     jump_addr;
    wire core_pkg::reg_addr_t rs1_addr;
    wire core_pkg::reg_addr_t rs2_addr;
    wire core_pkg::word_t     rs1_data;
    wire core_pkg::word_t     rs2_data;
    wire                      rd_we;
    wire core_pkg::reg_addr_t rd_addr;
    wire core_pkg::word_t     rd_data;
    wire                      mem_req;
    wire                      mem_we;
    wire core_pkg::word_t     mem_addr;
    wire core_pkg::word_t     mem_wdata;
    wire core_pkg::word_t     mem_rdata;

    fetch_stage #(
        .RESET_PC(RESET_PC)
    ) u_fetch_stage (
        .clk(clk),
        .rst_n_i(rst_n_i),
        .hold_i(hold),
        .halt_i(jtag_halt_flag_i),
        .jump_i(jump),
        .jump_addr_i(jump_addr),
        .fetch_data_i(fetch_data),
        .pc_o(pc),
        .inst_o(inst),
        .inst_addr_o(inst_addr)
    );

    decode_execute u_decode_execute (
        .inst_i(inst),
        .inst_addr_i(inst_addr),
        .rs1_data_i(rs1_data),
        .rs2_data_i(rs2_data),
        .mem_rdata_i(mem_rdata),
        .rs1_addr_o(rs1_addr),
        .rs2_addr_o(rs2_addr),
        .rd_addr_o(rd_addr),
        .rd_we_o(rd_we),
        .rd_data_o(rd_data),
        .mem_req_o(mem_req),
        .mem_we_o(mem_we),
        .mem_addr_o(mem_addr),
        .mem_wdata_o(mem_wdata),
        .jump_o(jump),
        .jump_addr_o(jump_addr)
    );

    regs u_regs (
        .clk(clk),
        .rst_n_i(rst_n_i),
        .rs1_addr_i(rs1_addr),
        .rs2_addr_i(rs2_addr),
        .rd_addr_i(rd_addr),
        .jtag_addr_i(jtag_reg_addr_i),
        .rd_we_i(rd_we),
        .jtag_we_i(jtag_reg_we_i),
        .rd_data_i(rd_data),
        .jtag_data_i(jtag_reg_data_i),
        .rs1_data_o(rs1_data),
        .rs2_data_o(rs2_data),
        .jtag_data_o(jtag_reg_data_o)
    );

    rib_bus u_rib_bus (
        .ex_req_i(mem_req),
        .ex_we_i(mem_we),
        .ex_addr_i(mem_addr),
        .ex_wdata_i(mem_wdata),
        .fetch_addr_i(pc),
        .s0_data_i(s0_data_i),
        .s1_data_i(s1_data_i),
        .ex_rdata_o(mem_rdata),
        .fetch_data_o(fetch_data),
        .hold_o(hold),
        .s0_addr_o(s0_addr_o),
        .s0_data_o(s0_data_o),
        .s1_addr_o(s1_addr_o),
        .s1_data_o(s1_data_o),
        .s0_we_o(s0_we_o),
        .s1_we_o(s1_we_o)
    );

endmodule

`default_nettype wire

//--- tests/tb_core_assertions.sv
`default_nettype none

module tb_core_assertions (
    input wire                  clk_i,
    input wire                  rst_n_i,
    input wire                  s0_we_i,
    input wire                  s1_we_i,
    input wire core_pkg::word_t x0_i
);

    timeunit 1ns;
    timeprecision 1ps;

    // only one slave may see a write strobe
    assert property (@(posedge clk_i) disable iff (!rst_n_i) !(s0_we_i && s1_we_i))
        else $error("both slave write enables high");

    // x0 is hardwired to zero
    assert property (@(posedge clk_i) disable iff (!rst_n_i) x0_i == '0)
        else $error("register x0 holds a nonzero value");

endmodule

// bus strobes seen at the core boundary, x0 inside the register file
bind core tb_core_assertions u_core_sva (
    .clk_i(clk),
    .rst_n_i(rst_n_i),
    .s0_we_i(s0_we_o),
    .s1_we_i(s1_we_o),
    .x0_i(u_regs.rf[0])
);

`default_nettype wire

//--- tests/tb_core.sv
`default_nettype none

module tb_core;

    timeunit 1ns;
    timeprecision 1ps;

    localparam core_pkg::word_t RESET_PC = 32'h0000_0000;
    localparam core_pkg::word_t JAL_SELF = 32'h0000_006f;
    localparam core_pkg::word_t RAM_BASE = 32'h1000_0000;
    localparam int ROM_WORDS = 64;
    localparam int RAM_WORDS = 16;

    logic                clk;
    logic                rst_n;
    core_pkg::reg_addr_t jtag_addr;
    core_pkg::word_t     jtag_wdata;
    logic                jtag_we;
    logic                halt;
    core_pkg::word_t     jtag_rdata;
    core_pkg::word_t     s0_addr_o;
    core_pkg::word_t     s0_data_o;
    core_pkg::word_t     s0_data_i;
    logic                s0_we_o;
    core_pkg::word_t     s1_addr_o;
    core_pkg::word_t     s1_data_o;
    core_pkg::word_t     s1_data_i;
    logic                s1_we_o;

    core_pkg::word_t rom [ROM_WORDS];
    core_pkg::word_t ram [RAM_WORDS];
    core_pkg::word_t mram [RAM_WORDS];
    core_pkg::word_t m_regs [32];
    core_pkg::word_t exp_addr [64];
    core_pkg::word_t exp_data [64];
    int              n_stores;
    int              st_idx;
    core_pkg::word_t rng;
    core_pkg::word_t final_pc;
    int              exec_count;
    int              cycle_limit;
    int              cycles;
    logic            reached;

    core #(
        .RESET_PC(RESET_PC)
    ) DUT (
        .clk(clk),
        .rst_n_i(rst_n),
        .jtag_reg_addr_i(jtag_addr),
        .jtag_reg_data_i(jtag_wdata),
        .jtag_reg_we_i(jtag_we),
        .jtag_reg_data_o(jtag_rdata),
        .jtag_halt_flag_i(halt),
        .s0_addr_o(s0_addr_o),
        .s0_data_o(s0_data_o),
        .s0_data_i(s0_data_i),
        .s0_we_o(s0_we_o),
        .s1_addr_o(s1_addr_o),
        .s1_data_o(s1_data_o),
        .s1_data_i(s1_data_i),
        .s1_we_o(s1_we_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // slaves answer in the same cycle
    assign s0_data_i = rom[s0_addr_o[7:2]];
    assign s1_data_i = ram[s1_addr_o[5:2]];

    function automatic core_pkg::word_t ram_fill(input core_pkg::word_t a);
        return (a * 32'h9e37_79b9) ^ 32'h5a5a_5a5a;
    endfunction

    function automatic core_pkg::word_t next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic core_pkg::reg_addr_t pick_reg(input core_pkg::word_t r);
        return 5'(r % 32'd15) + 5'd1;
    endfunction

    task automatic check_word(input string name, input core_pkg::word_t got,
                              input core_pkg::word_t exp);
        if (got !== exp) begin
            $display("Fail %0t %s got %h expected %h", $time, name, got, exp);
            $display("TB FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_addr(input string name, input core_pkg::word_t got,
                              input core_pkg::word_t exp);
        if (got !== exp) begin
            $display("Fail %0t %s store address got %h expected %h", $time, name, got, exp);
            $display("TB FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail %0t %s got %b expected %b", $time, name, got, exp);
            $display("TB FAILED");
            $fatal(1);
        end
    endtask

    // ram model, store checking and the run limit
    always @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < RAM_WORDS; i++) begin
                ram[i] <= ram_fill(RAM_BASE + 32'(i * 4));
            end
        end else begin
            // the program never writes the rom
            check_bit("s0_we_o", s0_we_o, 1'b0);
            if (s1_we_o) begin
                if (st_idx >= n_stores) begin
                    $display("store seen at %0t that the program should not make", $time);
                    $display("TB FAILED");
                    $fatal(1);
                end
                check_addr("s1_addr_o", s1_addr_o, exp_addr[st_idx]);
                check_word("s1_data_o", s1_data_o, exp_data[st_idx]);
                check_word("s0_data_o", s0_data_o, exp_data[st_idx]);
                ram[s1_addr_o[5:2]] <= s1_data_o;
                st_idx <= st_idx + 1;
            end
            if (!reached) begin
                cycles <= cycles + 1;
                if (cycles >= cycle_limit) begin
                    $display("timeout, the program never reached its final loop");
                    $display("TB FAILED");
                    $fatal(1);
                end
            end
        end
    end

    function automatic core_pkg::word_t enc_i(input logic [6:0] opc, input core_pkg::reg_addr_t rd,
            input logic [2:0] f3, input core_pkg::reg_addr_t rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic core_pkg::word_t enc_r(input logic [6:0] f7, input core_pkg::reg_addr_t rs2,
            input core_pkg::reg_addr_t rs1, input logic [2:0] f3, input core_pkg::reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic core_pkg::word_t enc_s(input core_pkg::reg_addr_t rs2,
            input core_pkg::reg_addr_t rs1, input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic core_pkg::word_t enc_b(input logic [2:0] f3, input core_pkg::reg_addr_t rs1,
            input core_pkg::reg_addr_t rs2, input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic core_pkg::word_t enc_u(input core_pkg::reg_addr_t rd, input logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic core_pkg::word_t enc_j(input core_pkg::reg_addr_t rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    task automatic build_program();
        int                  pc;
        core_pkg::word_t     r;
        core_pkg::reg_addr_t rd;
        core_pkg::reg_addr_t rs1;
        core_pkg::reg_addr_t rs2;
        core_pkg::word_t     count;
        pc = 0;
        for (int i = 0; i < ROM_WORDS; i++) begin
            rom[i] = core_pkg::NOP_INST;
        end
        // random alu mix on x1..x15
        for (int k = 0; k < 12; k++) begin
            r = next_rand();
            rd = pick_reg(r);
            rs1 = pick_reg(r >> 8);
            rs2 = pick_reg(r >> 16);
            case (r[30:28])
                3'd0, 3'd1: rom[pc] = enc_i(core_pkg::OP_IMM, rd, 3'd0, rs1, r[27:16]);
                3'd2: rom[pc] = enc_u(rd, r[31:12]);
                3'd3: rom[pc] = enc_r(7'h00, rs2, rs1, 3'b000, rd);
                3'd4: rom[pc] = enc_r(7'h20, rs2, rs1, 3'b000, rd);
                3'd5: rom[pc] = enc_r(7'h00, rs2, rs1, 3'b111, rd);
                3'd6: rom[pc] = enc_r(7'h00, rs2, rs1, 3'b110, rd);
                default: rom[pc] = enc_r(7'h00, rs2, rs1, 3'b100, rd);
            endcase
            pc++;
        end
        // x20 points at the ram
        rom[pc++] = enc_u(5'd20, 20'h10000);
        for (int k = 0; k < 4; k++) begin
            r = next_rand();
            rom[pc++] = enc_s(pick_reg(r), 5'd20, {6'b0, r[11:8], 2'b0});
            rom[pc++] = enc_i(core_pkg::OP_LOAD, pick_reg(r >> 16), 3'b010, 5'd20,
                              {6'b0, r[23:20], 2'b0});
        end
        // counted loop
        count = 32'd3 + (next_rand() % 32'd4);
        rom[pc++] = enc_i(core_pkg::OP_IMM, 5'd21, 3'd0, 5'd0, count[11:0]);
        rom[pc++] = enc_i(core_pkg::OP_IMM, 5'd22, 3'd0, 5'd22, 12'd7);
        rom[pc++] = enc_i(core_pkg::OP_IMM, 5'd21, 3'd0, 5'd21, 12'hfff);
        rom[pc++] = enc_b(3'b001, 5'd21, 5'd0, 13'h1ff8);
        // jal over a store and an addi that must never run
        rom[pc++] = enc_j(5'd23, 21'd12);
        rom[pc++] = enc_s(5'd22, 5'd20, 12'd0);
        rom[pc++] = enc_i(core_pkg::OP_IMM, 5'd24, 3'd0, 5'd0, 12'd99);
        rom[pc++] = enc_i(core_pkg::OP_IMM, 5'd25, 3'd0, 5'd23, 12'd1);
        final_pc = RESET_PC + 32'(pc * 4);
        rom[pc] = JAL_SELF;
    endtask

    // instruction set model, stops at the self loop
    function automatic int iss_run();
        core_pkg::word_t     pc;
        core_pkg::word_t     inst;
        core_pkg::word_t     a;
        core_pkg::word_t     b;
        core_pkg::word_t     val;
        core_pkg::word_t     nxt;
        core_pkg::word_t     addr;
        core_pkg::word_t     imm;
        logic                wr;
        core_pkg::reg_addr_t rd;
        int                  n;
        for (int i = 0; i < 32; i++) begin
            m_regs[i] = '0;
        end
        for (int i = 0; i < RAM_WORDS; i++) begin
            mram[i] = ram_fill(RAM_BASE + 32'(i * 4));
        end
        n_stores = 0;
        pc = RESET_PC;
        n = 0;
        while (n < 4096) begin
            inst = rom[pc[7:2]];
            if (inst == JAL_SELF) begin
                break;
            end
            rd = inst[11:7];
            a = m_regs[inst[19:15]];
            b = m_regs[inst[24:20]];
            imm = {{20{inst[31]}}, inst[31:20]};
            nxt = pc + 32'd4;
            wr = 1'b0;
            val = '0;
            case (inst[6:0])
                core_pkg::OP_LUI: begin
                    wr = 1'b1;
                    val = {inst[31:12], 12'b0};
                end
                core_pkg::OP_IMM: begin
                    wr = (inst[14:12] == 3'b000);
                    val = a + imm;
                end
                core_pkg::OP_REG: begin
                    wr = 1'b1;
                    case ({inst[31:25], inst[14:12]})
                        10'b0000000_000: val = a + b;
                        10'b0100000_000: val = a - b;
                        10'b0000000_111: val = a & b;
                        10'b0000000_110: val = a | b;
                        10'b0000000_100: val = a ^ b;
                        default: wr = 1'b0;
                    endcase
                end
                core_pkg::OP_LOAD: begin
                    addr = a + imm;
                    wr = 1'b1;
                    val = mram[addr[5:2]];
                end
                core_pkg::OP_STORE: begin
                    addr = a + {{20{inst[31]}}, inst[31:25], inst[11:7]};
                    mram[addr[5:2]] = b;
                    exp_addr[n_stores] = addr;
                    exp_data[n_stores] = b;
                    n_stores++;
                end
                core_pkg::OP_BRANCH: begin
                    if ((inst[14:12] == 3'b000 && a == b) || (inst[14:12] == 3'b001 && a != b)) begin
                        nxt = pc + {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
                    end
                end
                core_pkg::OP_JAL: begin
                    wr = 1'b1;
                    val = pc + 32'd4;
                    nxt = pc + {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
                end
                default: begin
                end
            endcase
            if (wr && rd != 5'd0) begin
                m_regs[rd] = val;
            end
            pc = nxt;
            n++;
        end
        return n;
    endfunction

    task automatic debug_write(input core_pkg::reg_addr_t a, input core_pkg::word_t v);
        @(negedge clk);
        jtag_addr = a;
        jtag_wdata = v;
        jtag_we = 1'b1;
        @(negedge clk);
        jtag_we = 1'b0;
    endtask

    initial begin
        core_pkg::word_t     r;
        core_pkg::word_t     v;
        core_pkg::reg_addr_t a;
        rst_n = 1'b0;
        jtag_addr = '0;
        jtag_wdata = '0;
        jtag_we = 1'b0;
        halt = 1'b0;
        reached = 1'b0;
        st_idx = 0;
        cycles = 0;
        cycle_limit = 100000;
        rng = 32'd19350;
        build_program();
        exec_count = iss_run();
        cycle_limit = 3 * exec_count + 200;

        repeat (2) @(posedge clk);
        @(negedge clk);
        check_word("s0_addr_o", s0_addr_o, RESET_PC);
        check_bit("s0_we_o", s0_we_o, 1'b0);
        check_bit("s1_we_o", s1_we_o, 1'b0);
        rst_n = 1'b1;

        while (s0_addr_o !== final_pc) begin
            @(negedge clk);
        end
        reached = 1'b1;
        halt = 1'b1;
        repeat (4) @(negedge clk);
        if (st_idx != n_stores) begin
            $display("only %0d of %0d expected stores were seen", st_idx, n_stores);
            $display("TB FAILED");
            $fatal(1);
        end

        // full register file against the model
        for (int i = 0; i < 32; i++) begin
            jtag_addr = 5'(i);
            @(posedge clk);
            check_word($sformatf("x%0d", i), jtag_rdata, m_regs[i]);
            @(negedge clk);
        end

        // debug writes while halted, the first one aimed at x0
        for (int k = 0; k < 8; k++) begin
            r = next_rand();
            v = next_rand();
            a = (k == 0) ? 5'd0 : pick_reg(r) + 5'(r[4]) * 5'd16;
            debug_write(a, v);
            if (a != 5'd0) begin
                m_regs[a] = v;
            end
            @(posedge clk);
            check_word($sformatf("x%0d", a), jtag_rdata, m_regs[a]);
        end

        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- riscv_soc.f
verilog/core_pkg.sv
verilog/bus_pkg.sv
verilog/fetch_stage.sv
verilog/regs.sv
verilog/decode_execute.sv
verilog/rib_bus.sv
verilog/core.sv
tests/tb_core_assertions.sv
tests/tb_core.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_core -f riscv_soc.f -o sim_core \
    || { echo "build failed"; exit 1; }

./obj_dir/sim_core > sim.log 2>&1
cat sim.log

grep -q "TB FAILED" sim.log && exit 1
grep -q "TB PASSED" sim.log && exit 0 || exit 1
